// ==== verilog.f ====
+incdir+sim
src/bomb_pkg.sv
src/wire_generator.sv
src/wire_cursor.sv
src/wire_cut_detector.sv
src/game_fsm.sv
src/wire_game_top.sv
sim/tb_wire_game.sv

// ==== Makefile ====
# Verilator build and run for the wire module testbench

VERILATOR  ?= verilator
TOP        ?= tb_wire_game
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/wire_model.svh ====
// wire puzzle reference model for the testbench
// xorshift random source and the right-wire rules of the defusal manual
`ifndef WIRE_MODEL_SVH
`define WIRE_MODEL_SVH

// one 32-bit xorshift step, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    return s ^ (s << 5);
endfunction

// wire to cut for num wires, colors packed 3 bits per slot, slot 0 lowest
function automatic int right_wire(input int num, input logic [17:0] cols);
    int cnt [5];                                    // wires per color
    int last_of [5];                                // highest slot per color
    int c;
    int last;                                       // position of the last wire
    int lc;                                         // color of the last wire
    for (int k = 0; k < 5; k++) begin
        cnt[k]     = 0;
        last_of[k] = 0;
    end
    for (int i = 0; i < num; i++) begin
        c = int'(cols[3*i +: 3]);
        if (c < 5) begin
            cnt[c]     += 1;
            last_of[c] = i;
        end
    end
    last = num - 1;
    lc   = int'(cols[3*last +: 3]);
    case (num)
        3: return (cnt[RED] == 0) ? 1 :
                  (lc == WHITE) ? last :
                  (cnt[BLUE] > 1) ? last_of[BLUE] : last;
        4: return (cnt[RED] > 1) ? last_of[RED] :
                  (cnt[RED] == 0 && lc == YELLOW) ? 0 :
                  (cnt[BLUE] == 1) ? 0 :
                  (cnt[YELLOW] > 1) ? last : 1;
        5: return (lc == BLACK) ? 3 :
                  (cnt[RED] == 1 && cnt[YELLOW] > 1) ? 0 :
                  (cnt[BLACK] == 0) ? 1 : 0;
        6: return (cnt[YELLOW] == 0) ? 2 :
                  (cnt[YELLOW] == 1 && cnt[WHITE] > 1) ? 3 :
                  (cnt[RED] == 0) ? last : 3;
        default: return -1;                         // no valid puzzle
    endcase
endfunction

`endif

// ==== sim/tb_wire_game.sv ====
// testbench for the wire module of the bomb game
// plays random games with xorshift button presses and checks screens,
// cursor, cuts, strikes and outcome against a model of the manual rules
module tb_wire_game
    import bomb_pkg::*;
();

    localparam int PERIOD    = 8;
    localparam int NUM_GAMES = 40;
    localparam int MAX_STEPS = 200;                 // presses allowed per game

    logic        clk;
    logic        nrst;
    logic        strobe;
    button_t     button;
    game_state_t game_state;
    play_state_t playing_state;
    wire_idx_t   wire_num;
    color_t      wire_color [NUM_WIRES];
    wire_idx_t   wire_pos;
    wire_mask_t  wire_status;
    logic        wire_clear;
    logic        wire_error;
    strike_t     strikes;

    logic [31:0] rng;                               // xorshift state
    int          errors;
    int          checks;
    logic        seen_clear;                        // strobes sampled mid press cycle
    logic        seen_error;
    int          model_pos;                         // expected cursor
    logic [5:0]  model_cut;                         // expected cut wires
    int          model_strikes;
    int          wins;
    int          losses;

    `include "wire_model.svh"

    wire_game_top #(.MAX_STRIKES(3), .LFSR_SEED(16'hace1)) i_wire_game_top (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    function automatic int unsigned draw(input int unsigned n);
        rng = xorshift32(rng);
        return rng % n;
    endfunction

    // one press, strobes sampled mid cycle, returns just after the edge
    task automatic press(input button_t btn);
        strobe = 1'b1;
        button = btn;
        #3;
        seen_clear = wire_clear;
        seen_error = wire_error;
        @(posedge clk);
        #1;
        strobe = 1'b0;
        button = BTN_NONE;
    endtask

    function automatic logic [17:0] packed_colors();
        logic [17:0] v;
        for (int i = 0; i < NUM_WIRES; i++) begin
            v[3*i +: 3] = wire_color[i];
        end
        return v;
    endfunction

    task automatic check_puzzle();
        check("wire_status", wire_status, 0);
        check("wire_pos", wire_pos, 0);
        if (wire_num < 3 || wire_num > 6) begin
            errors++;
            $display("wire count %0d at %0t is outside 3 to 6", wire_num, $time);
        end
        for (int i = 0; i < NUM_WIRES; i++) begin
            if (i >= wire_num) begin
                check($sformatf("wire_color[%0d]", i), wire_color[i], NO_WIRE);
            end else if (wire_color[i] > BLACK) begin
                errors++;
                $display("wire %0d at %0t has no real color (%0d)", i, $time, wire_color[i]);
            end
        end
    endtask

    // a stray arrow on the current screen must leave the puzzle alone
    task automatic stray_arrow();
        press((draw(2) == 0) ? BTN_LEFT : BTN_RIGHT);
        check("wire_pos", wire_pos, model_pos);
        check("wire_status", wire_status, model_cut);
    endtask

    task automatic open_wires();
        stray_arrow();
        press(BTN_SELECT);
        check("playing_state", playing_state, WIRE);
        check("wire_pos", wire_pos, model_pos);
        check("wire_status", wire_status, model_cut);
    endtask

    task automatic move_cursor();
        button_t btn;
        btn = (draw(2) == 0) ? BTN_LEFT : BTN_RIGHT;
        if (btn == BTN_LEFT && model_pos > 0) begin
            model_pos--;
        end else if (btn == BTN_RIGHT && model_pos < int'(wire_num) - 1) begin
            model_pos++;                                // clamp at the last wire
        end
        press(btn);
        check("wire_pos", wire_pos, model_pos);
    endtask

    task automatic cut_wire();
        int   right;
        logic fresh;                                    // wire still intact
        right = right_wire(int'(wire_num), packed_colors());
        fresh = !model_cut[model_pos];
        press(BTN_SELECT);
        check("wire_clear", seen_clear, fresh && model_pos == right);
        check("wire_error", seen_error, fresh && model_pos != right);
        if (fresh) begin
            model_cut[model_pos] = 1'b1;
            if (model_pos != right) begin
                model_strikes++;
            end
        end
        check("wire_status", wire_status, model_cut);
        check("strikes", strikes, model_strikes);
        if (fresh && model_pos == right) begin
            check("game_state", game_state, WON);
        end else if (model_strikes == 3) begin
            check("game_state", game_state, LOST);
        end else begin
            check("game_state", game_state, PLAY);
        end
    endtask

    task automatic play_game();
        int steps;
        int r;
        stray_arrow();                                  // still in MENU
        check("game_state", game_state, MENU);
        press(BTN_SELECT);
        check("game_state", game_state, PLAY);          // one edge after the press
        check("playing_state", playing_state, MOD);
        check("strikes", strikes, 0);
        model_pos     = 0;
        model_cut     = '0;
        model_strikes = 0;
        check_puzzle();
        open_wires();
        steps = 0;
        while (game_state == PLAY && steps < MAX_STEPS) begin
            r = draw(10);
            if (r < 6) begin
                move_cursor();
            end else if (r < 9) begin
                cut_wire();
            end else begin
                press(BTN_BACK);                        // back to module select
                check("playing_state", playing_state, MOD);
                open_wires();
            end
            steps++;
        end
        if (game_state == PLAY) begin
            errors++;
            $display("game still running at %0t after %0d presses", $time, MAX_STEPS);
        end else if (game_state == WON) begin
            wins++;
        end else begin
            losses++;
        end
        press(BTN_SELECT);
        check("game_state", game_state, MENU);
    endtask

    initial begin
        nrst          = 1'b0;
        strobe        = 1'b0;
        button        = BTN_NONE;
        rng           = 32'h8201_765b;
        errors        = 0;
        checks        = 0;
        wins          = 0;
        losses        = 0;
        model_pos     = 0;
        model_cut     = '0;
        model_strikes = 0;
        repeat (3) @(posedge clk);
        #1;
        nrst = 1'b1;
        check("game_state", game_state, MENU);
        check("playing_state", playing_state, MOD);
        check("strikes", strikes, 0);
        check("wire_num", wire_num, 3);
        check("wire_pos", wire_pos, 0);
        check("wire_status", wire_status, 0);
        check("wire_clear", wire_clear, 0);
        check("wire_error", wire_error, 0);
        for (int i = 0; i < NUM_WIRES; i++) begin
            check($sformatf("wire_color[%0d]", i), wire_color[i], NO_WIRE);
        end
        for (int g = 0; g < NUM_GAMES; g++) begin
            play_game();
        end
        if (wins == 0 || losses == 0) begin
            errors++;
            $display("random games never reached both outcomes");
        end
        $display("%0d games, %0d won, %0d lost, %0d checks, %0d errors",
                 NUM_GAMES, wins, losses, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== src/wire_game_top.sv ====
// wire module of the bomb game
// game controller, puzzle generator, wire cursor and cut detector
// joined into one block driven by clean button presses
module wire_game_top
    import bomb_pkg::*;
#(
    parameter int          MAX_STRIKES = 3,
    parameter logic [15:0] LFSR_SEED   = 16'hace1
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        strobe,                     // one cycle per press
    input  button_t     button,
    output game_state_t game_state,
    output play_state_t playing_state,
    output wire_idx_t   wire_num,
    output color_t      wire_color [NUM_WIRES],
    output wire_idx_t   wire_pos,
    output wire_mask_t  wire_status,
    output logic        wire_clear,
    output logic        wire_error,
    output strike_t     strikes
);

    logic activate_rand;                            // start of game, new puzzle

    game_fsm #(
        .MAX_STRIKES (MAX_STRIKES)
    ) i_game_fsm (
        .clk           (clk),
        .nrst          (nrst),
        .strobe        (strobe),
        .button        (button),
        .wire_clear    (wire_clear),
        .wire_error    (wire_error),
        .game_state    (game_state),
        .playing_state (playing_state),
        .activate_rand (activate_rand),
        .strikes       (strikes)
    );

    wire_generator #(
        .LFSR_SEED (LFSR_SEED)
    ) i_wire_generator (
        .clk           (clk),
        .nrst          (nrst),
        .activate_rand (activate_rand),
        .wire_num      (wire_num),
        .wire_color    (wire_color)
    );

    wire_cursor i_wire_cursor (
        .clk           (clk),
        .nrst          (nrst),
        .activate_rand (activate_rand),
        .strobe        (strobe),
        .button        (button),
        .playing_state (playing_state),
        .wire_num      (wire_num),
        .wire_pos      (wire_pos)
    );

    wire_cut_detector i_wire_cut_detector (
        .clk              (clk),
        .nrst             (nrst),
        .activate_rand    (activate_rand),
        .strobe           (strobe),
        .playing_state_in (playing_state),
        .button           (button),
        .wire_num         (wire_num),
        .wire_pos         (wire_pos),
        .wire_color       (wire_color),
        .wire_status      (wire_status),
        .wire_clear       (wire_clear),
        .wire_error       (wire_error)
    );

endmodule

// ==== src/game_fsm.sv ====
// game controller
// game flow MENU, PLAY, LOST, WON plus the screen inside PLAY, with
// a strike counter fed by the wire errors; fires activate_rand on the
// press that starts a game
module game_fsm
    import bomb_pkg::*;
#(
    parameter int MAX_STRIKES = 3                   // strikes that lose the game
) (
    input  logic        clk,
    input  logic        nrst,
    input  logic        strobe,
    input  button_t     button,
    input  logic        wire_clear,                 // right wire cut
    input  logic        wire_error,                 // wrong wire cut
    output game_state_t game_state,
    output play_state_t playing_state,
    output logic        activate_rand,              // new game pulse
    output strike_t     strikes
);

    game_state_t game_next;
    play_state_t play_next;
    strike_t     strikes_next;
    strike_t     strikes_inc;                       // count after one more error
    logic        select_press;
    logic        back_press;

    assign select_press  = strobe && (button == BTN_SELECT);
    assign back_press    = strobe && (button == BTN_BACK);
    assign activate_rand = (game_state == MENU) && select_press;
    assign strikes_inc   = strikes + strike_t'(1);

    always_comb begin
        game_next    = game_state;
        play_next    = playing_state;
        strikes_next = strikes;
        case (game_state)
            MENU: begin
                if (activate_rand) begin
                    game_next    = PLAY;
                    play_next    = MOD;
                    strikes_next = '0;
                end
            end
            PLAY: begin
                if (wire_clear) begin
                    game_next = WON;
                    play_next = MOD;                         // leave the wire screen
                end else if (wire_error) begin
                    strikes_next = strikes_inc;
                    if (int'(strikes_inc) == MAX_STRIKES) begin
                        game_next = LOST;
                        play_next = MOD;
                    end
                end else if (playing_state == MOD && select_press) begin
                    play_next = WIRE;                        // open the wire puzzle
                end else if (playing_state == WIRE && back_press) begin
                    play_next = MOD;
                end
            end
            LOST, WON: begin
                if (select_press) begin
                    game_next = MENU;
                end
            end
            default: game_next = MENU;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            game_state    <= MENU;
            playing_state <= MOD;
            strikes       <= '0;
        end else begin
            game_state    <= game_next;
            playing_state <= play_next;
            strikes       <= strikes_next;
        end
    end

endmodule

// ==== src/wire_cut_detector.sv ====
// wire cut detector
// works out the right wire from the color counts of the puzzle and
// judges every cut on the wire screen: a clear or error strobe in the
// cycle of the press, and a per-wire cut status for the game
module wire_cut_detector
    import bomb_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        activate_rand,              // new puzzle, all wires uncut
    input  logic        strobe,
    input  play_state_t playing_state_in,
    input  button_t     button,
    input  wire_idx_t   wire_num,                   // wires present, 3 to 6
    input  wire_idx_t   wire_pos,                   // wire under the cursor
    input  color_t      wire_color [NUM_WIRES],
    output wire_mask_t  wire_status,                // 1 = cut
    output logic        wire_clear,                 // right wire cut
    output logic        wire_error                  // wrong wire cut
);

    logic [2:0] color_cnt [5];                      // wires of each real color
    wire_idx_t  last_of [5];                        // last slot of each color
    wire_idx_t  last_wire;                          // position of the last wire
    color_t     last_color;                         // its color
    wire_idx_t  right_wire;                         // the wire to cut
    logic       cut_press;                          // SELECT on the wire screen
    logic       fresh_cut;                          // ... on a wire still intact

    assign last_wire  = wire_num - wire_idx_t'(1);
    assign last_color = wire_color[last_wire];

    // color census, empty slots skipped
    always_comb begin
        for (int c = 0; c < 5; c++) begin
            color_cnt[c] = 3'd0;
            last_of[c]   = '0;
        end
        for (int i = 0; i < NUM_WIRES; i++) begin
            if (wire_color[i] < NO_WIRE) begin
                color_cnt[wire_color[i]] = color_cnt[wire_color[i]] + 3'd1;
                last_of[wire_color[i]]   = wire_idx_t'(i);   // later slots overwrite
            end
        end
    end

    // defusal rules, one set per wire count
    always_comb begin
        right_wire = '0;
        case (wire_num)
            3'd3: begin
                if (color_cnt[RED] == 3'd0) begin
                    right_wire = wire_idx_t'(1);             // no red
                end else if (last_color == WHITE) begin
                    right_wire = last_wire;
                end else if (color_cnt[BLUE] > 3'd1) begin
                    right_wire = last_of[BLUE];              // last blue
                end else begin
                    right_wire = last_wire;
                end
            end
            3'd4: begin
                if (color_cnt[RED] > 3'd1) begin
                    right_wire = last_of[RED];               // last red
                end else if (color_cnt[RED] == 3'd0 && last_color == YELLOW) begin
                    right_wire = wire_idx_t'(0);
                end else if (color_cnt[BLUE] == 3'd1) begin
                    right_wire = wire_idx_t'(0);
                end else if (color_cnt[YELLOW] > 3'd1) begin
                    right_wire = last_wire;
                end else begin
                    right_wire = wire_idx_t'(1);
                end
            end
            3'd5: begin
                if (last_color == BLACK) begin
                    right_wire = wire_idx_t'(3);
                end else if (color_cnt[RED] == 3'd1 && color_cnt[YELLOW] > 3'd1) begin
                    right_wire = wire_idx_t'(0);
                end else if (color_cnt[BLACK] == 3'd0) begin
                    right_wire = wire_idx_t'(1);
                end else begin
                    right_wire = wire_idx_t'(0);
                end
            end
            3'd6: begin
                if (color_cnt[YELLOW] == 3'd0) begin
                    right_wire = wire_idx_t'(2);
                end else if (color_cnt[YELLOW] == 3'd1 && color_cnt[WHITE] > 3'd1) begin
                    right_wire = wire_idx_t'(3);
                end else if (color_cnt[RED] == 3'd0) begin
                    right_wire = last_wire;
                end else begin
                    right_wire = wire_idx_t'(3);
                end
            end
            default: right_wire = '0;                        // count never leaves 3..6
        endcase
    end

    assign cut_press  = strobe && (playing_state_in == WIRE) && (button == BTN_SELECT);
    assign fresh_cut  = cut_press && !wire_status[wire_pos];   // cut wires are dead
    assign wire_clear = fresh_cut && (wire_pos == right_wire);
    assign wire_error = fresh_cut && (wire_pos != right_wire);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wire_status <= '0;
        end else if (activate_rand) begin
            wire_status <= '0;                               // fresh puzzle
        end else if (fresh_cut) begin
            wire_status[wire_pos] <= 1'b1;
        end
    end

endmodule

// ==== src/wire_cursor.sv ====
// wire cursor
// holds the selected wire, moved by LEFT and RIGHT on the wire screen
// and clamped to the wires present, no wrap at either end
module wire_cursor
    import bomb_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  logic        activate_rand,              // new puzzle, cursor home
    input  logic        strobe,                     // one cycle per press
    input  button_t     button,
    input  play_state_t playing_state,
    input  wire_idx_t   wire_num,                   // wires present
    output wire_idx_t   wire_pos                    // selected wire, 0 is leftmost
);

    logic      move_press;                          // press that may move the cursor
    wire_idx_t last_pos;                            // rightmost wire

    assign move_press = strobe && (playing_state == WIRE);
    assign last_pos   = wire_num - wire_idx_t'(1);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            wire_pos <= '0;
        end else if (activate_rand) begin
            wire_pos <= '0;                                  // start on the first wire
        end else if (move_press) begin
            if (button == BTN_LEFT && wire_pos != '0) begin
                wire_pos <= wire_pos - wire_idx_t'(1);       // stop at wire 0
            end else if (button == BTN_RIGHT && wire_pos < last_pos) begin
                wire_pos <= wire_pos + wire_idx_t'(1);       // stop at the last wire
            end
        end
    end

endmodule

// ==== src/wire_generator.sv ====
// wire puzzle generator
// a free running 16-bit fibonacci LFSR is sampled on activate_rand
// to draw the wire count (3 to 6) and a color for every present wire
module wire_generator
    import bomb_pkg::*;
#(
    parameter logic [15:0] LFSR_SEED = 16'hace1     // nonzero lfsr start value
) (
    input  logic      clk,
    input  logic      nrst,
    input  logic      activate_rand,                // new game pulse
    output wire_idx_t wire_num,                     // wires present, 3 to 6
    output color_t    wire_color [NUM_WIRES]        // color per slot, NO_WIRE if empty
);

    logic [15:0] lfsr;                              // random source
    logic        lfsr_fb;                           // feedback bit
    wire_idx_t   rand_num;                          // wire count drawn from lfsr
    color_t      rand_color [NUM_WIRES];            // colors drawn from lfsr

    // fold a 3-bit field into the five real colors
    function automatic color_t mod5(input logic [2:0] v);
        return (v >= 3'd5) ? color_t'(v - 3'd5) : color_t'(v);
    endfunction

    assign lfsr_fb  = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // taps 16 14 13 11
    assign rand_num = wire_idx_t'(3'd3 + {1'b0, lfsr[1:0]});      // 3 plus two low bits

    always_comb begin
        for (int i = 0; i < NUM_WIRES; i++) begin
            if (wire_idx_t'(i) < rand_num) begin
                rand_color[i] = mod5(lfsr[2*i+2 +: 3]);    // overlapping 3-bit fields
            end else begin
                rand_color[i] = NO_WIRE;                    // slot past the last wire
            end
        end
    end

    // lfsr steps every cycle, game or not
    always_ff @(posedge clk) begin
        if (!nrst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    // capture the puzzle on entry to PLAY
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wire_num <= wire_idx_t'(3);
            for (int i = 0; i < NUM_WIRES; i++) begin
                wire_color[i] <= NO_WIRE;
            end
        end else if (activate_rand) begin
            wire_num <= rand_num;
            for (int i = 0; i < NUM_WIRES; i++) begin
                wire_color[i] <= rand_color[i];
            end
        end
    end

endmodule

// ==== src/bomb_pkg.sv ====
// bomb defusal game definitions
// game and screen state encodings, push button codes, wire colors
// and the vector widths shared by the wire puzzle blocks
package bomb_pkg;

    // game flow
    typedef enum logic [2:0] {
        MENU = 3'd0,                                // waiting for a new game
        PLAY = 3'd1,                                // bomb is live
        LOST = 3'd2,                                // too many strikes
        WON  = 3'd3                                 // module defused
    } game_state_t;

    // screen shown while playing
    typedef enum logic [2:0] {
        MOD  = 3'd0,                                // module select screen
        MAZE = 3'd1,                                // maze module, not built here
        WIRE = 3'd2                                 // wire puzzle
    } play_state_t;

    typedef logic [5:0] button_t;                   // one-hot, one bit per push button

    localparam button_t BTN_SELECT = 6'b000001;
    localparam button_t BTN_UP     = 6'b000010;
    localparam button_t BTN_RIGHT  = 6'b000100;
    localparam button_t BTN_DOWN   = 6'b001000;
    localparam button_t BTN_LEFT   = 6'b010000;
    localparam button_t BTN_BACK   = 6'b100000;
    localparam button_t BTN_NONE   = 6'b000000;

    typedef logic [2:0] color_t;                    // wire color code

    localparam color_t RED     = 3'd0;
    localparam color_t WHITE   = 3'd1;
    localparam color_t YELLOW  = 3'd2;
    localparam color_t BLUE    = 3'd3;
    localparam color_t BLACK   = 3'd4;
    localparam color_t NO_WIRE = 3'd5;              // empty slot

    localparam int NUM_WIRES = 6;                   // wire slots on the module

    typedef logic [2:0] wire_idx_t;                 // wire position or wire count
    typedef logic [5:0] wire_mask_t;                // one bit per wire slot
    typedef logic [1:0] strike_t;                   // strike count

endpackage
